//--- logic/ctl_settings.svh
/* Recovery control settings
   ISA field encodings and event queue sizing */

`ifndef CTL_SETTINGS_SVH
`define CTL_SETTINGS_SVH

`define CTL_ILEN		32
`define CTL_EVQ_DEPTH	4	// 2, 8 and 16 also supported

// Major opcodes
`define OPCODE_JAL		7'b1101111
`define OPCODE_BRANCH	7'b1100011
`define OPCODE_LOAD		7'b0000011
`define OPCODE_STORE	7'b0100011
`define OPCODE_MISC_MEM	7'b0001111
`define OPCODE_SYSTEM	7'b1110011

// funct3 values
`define FUNCT3_FENCE	3'b000
`define FUNCT3_FENCE_I	3'b001
`define FUNCT3_PRIV		3'b000	// ECALL, EBREAK, SFENCE.VMA

`define FUNCT7_SFENCE_VMA	7'b0001001

// imm[11:0] of the privileged SYSTEM group
`define IMM_ECALL		12'h000
`define IMM_EBREAK		12'h001

`endif

//--- logic/ctl_pkg.sv
/* Recovery control types
   Event classes, exception codes, TLB flush kinds, FSM states, event and command words */

`default_nettype none

package ctl_pkg;

	typedef enum logic [3:0] {
		EV_REDIRECT,	// Mispredicted jump or branch
		EV_TRAP,		// Faulting load or store
		EV_FENCE,
		EV_FENCE_I,
		EV_SFENCE,
		EV_ECALL,
		EV_EBREAK
	} event_class_e;

	// mcause encodings where they exist
	typedef enum logic [3:0] {
		E_I_MISALIGNED		= 4'd0,
		E_I_ACCESS_FAULT	= 4'd1,
		E_ILLEGAL_INSTR		= 4'd2,
		E_LD_MISALIGNED		= 4'd4,
		E_LD_ACCESS_FAULT	= 4'd5,
		E_ST_MISALIGNED		= 4'd6,
		E_ST_ACCESS_FAULT	= 4'd7,
		E_I_PAGE_FAULT		= 4'd12,
		E_LD_PAGE_FAULT		= 4'd13,
		E_NONE				= 4'd14,	// Reserved code reused as no exception
		E_ST_PAGE_FAULT		= 4'd15
	} except_code_e;

	typedef enum logic [1:0] {
		NO_FLUSH	= 2'd0,
		FLUSH_ASID	= 2'd1,
		FLUSH_ALL	= 2'd2
	} tlb_flush_e;

	typedef enum logic [3:0] {
		ST_RESET,
		ST_IDLE,
		ST_REDIRECT,
		ST_TRAP,
		ST_FENCE,
		ST_FENCE_I,
		ST_SFENCE_SYNC,	// Wait for L1-D/L2 sync
		ST_SFENCE_CLR,
		ST_ECALL,
		ST_EBREAK
	} cu_state_e;

	typedef struct packed {
		event_class_e	ev_class;
		except_code_e	ex_code;
	} ctl_event_t;

	typedef struct packed {
		logic			flush;
		logic			abort;
		logic			clr_l1tlb;
		logic			clr_l2tlb;
		logic			clr_dmshr;
		logic			synch_l1dc_l2c;
		tlb_flush_e		l1tlb_flush;
		tlb_flush_e		l2tlb_flush;
	} ctl_cmd_t;

endpackage

`default_nettype wire

//--- logic/instr_classifier.sv
/* Instruction classifier
   Decodes the instruction stream and registers one control event per actionable instruction */

`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module instr_classifier (
	input  logic					clk_i,
	input  logic					rst_n_i,
	input  logic					instr_valid_i,
	input  logic [`CTL_ILEN-1:0]	instr_i,
	input  logic					except_raised_i,
	input  ctl_pkg::except_code_e	except_code_i,
	output logic					evt_push_o,
	output ctl_pkg::ctl_event_t		evt_o
);
	import ctl_pkg::*;

	logic [6:0]		opcode;
	logic [2:0]		funct3;
	logic [6:0]		funct7;
	logic [11:0]	imm;

	logic			actionable;
	ctl_event_t		evt_d;
	logic			evt_push_q;
	ctl_event_t		evt_q;

	assign opcode	= instr_i[6:0];
	assign funct3	= instr_i[14:12];
	assign funct7	= instr_i[31:25];
	assign imm		= instr_i[31:20];

	always_comb begin
		actionable		= 1'b0;
		evt_d.ev_class	= EV_REDIRECT;
		evt_d.ex_code	= E_NONE;	// Only traps carry a real code

		if (instr_valid_i) begin
			case (opcode)
				`OPCODE_JAL, `OPCODE_BRANCH: begin
					// Misprediction arrives as an exception flag
					if (except_raised_i) begin
						actionable		= 1'b1;
						evt_d.ev_class	= EV_REDIRECT;
					end
				end
				`OPCODE_LOAD, `OPCODE_STORE: begin
					if (except_raised_i) begin
						actionable		= 1'b1;
						evt_d.ev_class	= EV_TRAP;
						evt_d.ex_code	= except_code_i;
					end
				end
				`OPCODE_MISC_MEM: begin
					if (funct3 == `FUNCT3_FENCE) begin
						actionable		= 1'b1;
						evt_d.ev_class	= EV_FENCE;
					end else if (funct3 == `FUNCT3_FENCE_I) begin
						actionable		= 1'b1;
						evt_d.ev_class	= EV_FENCE_I;
					end
				end
				`OPCODE_SYSTEM: begin
					if (funct3 == `FUNCT3_PRIV) begin
						if (funct7 == `FUNCT7_SFENCE_VMA) begin
							actionable		= 1'b1;
							evt_d.ev_class	= EV_SFENCE;
						end else if (imm == `IMM_ECALL) begin
							actionable		= 1'b1;
							evt_d.ev_class	= EV_ECALL;
						end else if (imm == `IMM_EBREAK) begin
							actionable		= 1'b1;
							evt_d.ev_class	= EV_EBREAK;
						end
					end
				end
				default: ;	// Nothing to recover
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			evt_push_q <= 1'b0;
		end else begin
			evt_push_q <= actionable;	// One-cycle push strobe
		end
	end

	always_ff @(posedge clk_i) begin
		if (actionable) begin
			evt_q <= evt_d;
		end
	end

	assign evt_push_o	= evt_push_q;
	assign evt_o		= evt_q;

endmodule

`default_nettype wire

//--- logic/event_queue.sv
/* Control event queue
   Circular FIFO of pending events, stall raised one entry early for the in-flight event */

`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module event_queue (
	input  logic				clk_i,
	input  logic				rst_n_i,
	input  logic				push_i,
	input  ctl_pkg::ctl_event_t	evt_i,
	input  logic				pop_i,
	output ctl_pkg::ctl_event_t	head_o,
	output logic				empty_o,
	output logic				stall_o
);
	import ctl_pkg::*;

	localparam int DEPTH = `CTL_EVQ_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	ctl_event_t			mem [DEPTH];
	logic [PTR_W-1:0]	wr_ptr_q;
	logic [PTR_W-1:0]	rd_ptr_q;
	logic [CNT_W-1:0]	count_q;
	logic				full;
	logic				do_push;
	logic				do_pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full		= (count_q == CNT_W'(DEPTH));
	assign empty_o	= (count_q == '0);
	assign do_push	= push_i && !full;
	assign do_pop	= pop_i && !empty_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q	<= '0;
			rd_ptr_q	<= '0;
			count_q		<= '0;
		end else begin
			if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
			if (do_pop) rd_ptr_q <= ptr_next(rd_ptr_q);
			case ({do_push, do_pop})
				2'b10:		count_q <= count_q + 1'b1;
				2'b01:		count_q <= count_q - 1'b1;
				default:	count_q <= count_q;	// Idle or push with pop
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem[wr_ptr_q] <= evt_i;
		end
	end

	assign head_o = mem[rd_ptr_q];

	// Room left for the event still in the classifier register
	assign stall_o = (count_q >= CNT_W'(DEPTH - 1));

	// Back-pressure contract with the instruction source
	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_i |-> !full)
		else $error("event queue overflow, push while full");

	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pop_i |-> !empty_o)
		else $error("event queue underflow, pop while empty");

endmodule

`default_nettype wire

//--- logic/recovery_fsm.sv
/* Recovery FSM
   Pops control events one at a time and drives the flush, clear and sync command word */

`timescale 1ns/1ps
`default_nettype none

module recovery_fsm (
	input  logic				clk_i,
	input  logic				rst_n_i,
	input  logic				evq_empty_i,
	input  ctl_pkg::ctl_event_t	evq_head_i,
	input  logic				l2c_update_done_i,
	output logic				evq_pop_o,
	output ctl_pkg::ctl_cmd_t	cmd_o,
	output logic				busy_o
);
	import ctl_pkg::*;

	cu_state_e		state_q;
	cu_state_e		state_d;
	except_code_e	code_q;	// Code of the event being handled

	// One event per visit to idle
	assign evq_pop_o = (state_q == ST_IDLE) && !evq_empty_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_RESET;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (evq_pop_o) begin
			code_q <= evq_head_i.ex_code;
		end
	end

	always_comb begin
		state_d = ST_IDLE;

		case (state_q)
			ST_IDLE: begin
				if (!evq_empty_i) begin
					case (evq_head_i.ev_class)
						EV_REDIRECT:	state_d = ST_REDIRECT;
						EV_TRAP:		state_d = ST_TRAP;
						EV_FENCE:		state_d = ST_FENCE;
						EV_FENCE_I:		state_d = ST_FENCE_I;
						EV_SFENCE:		state_d = ST_SFENCE_SYNC;
						EV_ECALL:		state_d = ST_ECALL;
						EV_EBREAK:		state_d = ST_EBREAK;
						default:		state_d = ST_IDLE;
					endcase
				end
			end
			ST_SFENCE_SYNC: begin
				// Hold until the L2 side reports the write-back done
				state_d = l2c_update_done_i ? ST_SFENCE_CLR : ST_SFENCE_SYNC;
			end
			default: state_d = ST_IDLE;	// All other states take one cycle
		endcase
	end

	always_comb begin
		cmd_o = '0;

		case (state_q)
			ST_RESET: begin
				cmd_o.flush			= 1'b1;
				cmd_o.clr_l1tlb		= 1'b1;
				cmd_o.clr_l2tlb		= 1'b1;
				cmd_o.clr_dmshr		= 1'b1;
				cmd_o.l1tlb_flush	= FLUSH_ALL;
				cmd_o.l2tlb_flush	= FLUSH_ALL;
			end
			ST_REDIRECT, ST_ECALL: begin
				cmd_o.flush			= 1'b1;
				cmd_o.l1tlb_flush	= FLUSH_ASID;
				cmd_o.l2tlb_flush	= FLUSH_ASID;
			end
			ST_TRAP: begin
				cmd_o.flush = 1'b1;
				case (code_q)
					E_I_MISALIGNED, E_I_ACCESS_FAULT, E_I_PAGE_FAULT: begin
						cmd_o.clr_l1tlb = 1'b1;
						cmd_o.clr_l2tlb = 1'b1;
					end
					E_LD_MISALIGNED, E_LD_ACCESS_FAULT, E_LD_PAGE_FAULT,
					E_ST_MISALIGNED, E_ST_ACCESS_FAULT, E_ST_PAGE_FAULT: begin
						cmd_o.clr_dmshr = 1'b1;	// Drop pending data misses
					end
					E_ILLEGAL_INSTR: begin
						cmd_o.abort = 1'b1;
					end
					default: ;	// Flush only
				endcase
			end
			ST_FENCE: begin
				cmd_o.flush = 1'b1;
			end
			ST_FENCE_I: begin
				cmd_o.clr_l1tlb = 1'b1;
				cmd_o.clr_l2tlb = 1'b1;
			end
			ST_SFENCE_SYNC: begin
				cmd_o.synch_l1dc_l2c = 1'b1;
			end
			ST_SFENCE_CLR: begin
				cmd_o.clr_l1tlb		= 1'b1;
				cmd_o.clr_l2tlb		= 1'b1;
				cmd_o.clr_dmshr		= 1'b1;
				cmd_o.l1tlb_flush	= FLUSH_ALL;
				cmd_o.l2tlb_flush	= FLUSH_ALL;
			end
			ST_EBREAK: begin
				cmd_o.flush = 1'b1;
				cmd_o.abort = 1'b1;
			end
			default: ;	// Idle
		endcase
	end

	assign busy_o = (state_q != ST_IDLE);

	// Only the SFENCE sync wait may stretch a handling visit
	a_one_cycle_visit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(state_q != ST_IDLE && state_q != ST_SFENCE_SYNC) |=> (state_q == ST_IDLE))
		else $error("recovery state held longer than one cycle");

endmodule

`default_nettype wire

//--- logic/recovery_ctl_top.sv
/* Recovery control unit
   Classifier feeding the event queue, drained by the recovery FSM */

`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module recovery_ctl_top (
	input  logic					clk_i,
	input  logic					rst_n_i,
	input  logic					instr_valid_i,
	input  logic [`CTL_ILEN-1:0]	instr_i,
	input  logic					except_raised_i,
	input  ctl_pkg::except_code_e	except_code_i,
	input  logic					l2c_update_done_i,
	output ctl_pkg::ctl_cmd_t		cmd_o,
	output logic					busy_o,
	output logic					stall_o
);
	import ctl_pkg::*;

	logic			evt_push;
	ctl_event_t		evt;
	logic			evq_empty;
	ctl_event_t		evq_head;
	logic			evq_pop;

	instr_classifier instr_classifier_inst (
		.clk_i				(clk_i),
		.rst_n_i			(rst_n_i),
		.instr_valid_i		(instr_valid_i),
		.instr_i			(instr_i),
		.except_raised_i	(except_raised_i),
		.except_code_i		(except_code_i),
		.evt_push_o			(evt_push),
		.evt_o				(evt)
	);

	event_queue event_queue_inst (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.push_i		(evt_push),
		.evt_i		(evt),
		.pop_i		(evq_pop),
		.head_o		(evq_head),
		.empty_o	(evq_empty),
		.stall_o	(stall_o)
	);

	recovery_fsm recovery_fsm_inst (
		.clk_i				(clk_i),
		.rst_n_i			(rst_n_i),
		.evq_empty_i		(evq_empty),
		.evq_head_i			(evq_head),
		.l2c_update_done_i	(l2c_update_done_i),
		.evq_pop_o			(evq_pop),
		.cmd_o				(cmd_o),
		.busy_o				(busy_o)
	);

endmodule

`default_nettype wire

//--- test/recovery_ctl_tb.sv
/* Recovery control testbench
   Table-driven instruction stream with a monitor checking every command word in order */

`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module recovery_ctl_tb;
	import ctl_pkg::*;

	localparam int STALL_LIMIT	= 200;
	localparam int DRAIN_LIMIT	= 500;
	localparam int BURST_N		= `CTL_EVQ_DEPTH + 2;	// Enough to overrun the stall level

	// RV32 encodings used as stimulus
	localparam logic [`CTL_ILEN-1:0] INSN_ADD		= 32'h003100B3;
	localparam logic [`CTL_ILEN-1:0] INSN_JAL		= 32'h0000006F;
	localparam logic [`CTL_ILEN-1:0] INSN_BEQ		= 32'h00000063;
	localparam logic [`CTL_ILEN-1:0] INSN_LW		= 32'h00012083;
	localparam logic [`CTL_ILEN-1:0] INSN_SW		= 32'h00112023;
	localparam logic [`CTL_ILEN-1:0] INSN_FENCE		= 32'h0FF0000F;
	localparam logic [`CTL_ILEN-1:0] INSN_FENCE_I	= 32'h0000100F;
	localparam logic [`CTL_ILEN-1:0] INSN_ECALL		= 32'h00000073;
	localparam logic [`CTL_ILEN-1:0] INSN_EBREAK	= 32'h00100073;
	localparam logic [`CTL_ILEN-1:0] INSN_SFENCE	= 32'h12000073;
	localparam logic [`CTL_ILEN-1:0] INSN_MRET		= 32'h30200073;
	localparam logic [`CTL_ILEN-1:0] INSN_CSRRW		= 32'h30001073;

	typedef struct packed {
		logic [`CTL_ILEN-1:0]	instr;
		logic					exc;
		except_code_e			code;
		logic					has_cmd;	// Actionable entry
		ctl_cmd_t				cmd;
	} stim_t;

	logic					clk_i = 1'b0;	// Low before any process starts
	logic					rst_n_i;
	logic					instr_valid_i;
	logic [`CTL_ILEN-1:0]	instr_i;
	logic					except_raised_i;
	except_code_e			except_code_i;
	logic					l2c_update_done_i;
	ctl_cmd_t				cmd_o;
	logic					busy_o;
	logic					stall_o;

	stim_t		table_q[$];
	ctl_cmd_t	exp_q[$];	// Commands still owed by the DUT
	ctl_cmd_t	prev_cmd;
	ctl_cmd_t	mon_exp;
	int			errors;
	int			timeouts;
	int			checks;
	int			cmds_seen;

	recovery_ctl_top recovery_ctl_top_inst (
		.clk_i				(clk_i),
		.rst_n_i			(rst_n_i),
		.instr_valid_i		(instr_valid_i),
		.instr_i			(instr_i),
		.except_raised_i	(except_raised_i),
		.except_code_i		(except_code_i),
		.l2c_update_done_i	(l2c_update_done_i),
		.cmd_o				(cmd_o),
		.busy_o				(busy_o),
		.stall_o			(stall_o)
	);

	initial begin
		forever #10 clk_i = ~clk_i;
	end

	function automatic ctl_cmd_t make_cmd(input logic flush, input logic abort,
		input logic clr_tlbs, input logic clr_mshr, input logic sync, input tlb_flush_e tlb);
		ctl_cmd_t c;
		c.flush				= flush;
		c.abort				= abort;
		c.clr_l1tlb			= clr_tlbs;
		c.clr_l2tlb			= clr_tlbs;
		c.clr_dmshr			= clr_mshr;
		c.synch_l1dc_l2c	= sync;
		c.l1tlb_flush		= tlb;
		c.l2tlb_flush		= tlb;
		return c;
	endfunction

	task automatic add_entry(input logic [`CTL_ILEN-1:0] instr, input logic exc,
		input except_code_e code, input logic has_cmd, input ctl_cmd_t cmd);
		stim_t e;
		e.instr		= instr;
		e.exc		= exc;
		e.code		= code;
		e.has_cmd	= has_cmd;
		e.cmd		= cmd;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		ctl_cmd_t redirect;
		ctl_cmd_t i_fault;
		ctl_cmd_t ls_fault;
		ctl_cmd_t kill;
		ctl_cmd_t fence;
		ctl_cmd_t fence_i;
		ctl_cmd_t none;
		redirect	= make_cmd(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, FLUSH_ASID);	// Also ECALL
		i_fault		= make_cmd(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, NO_FLUSH);
		ls_fault	= make_cmd(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, NO_FLUSH);
		kill		= make_cmd(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, NO_FLUSH);	// Illegal, EBREAK
		fence		= make_cmd(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, NO_FLUSH);
		fence_i		= make_cmd(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, NO_FLUSH);
		none		= '0;
		add_entry(INSN_ADD,		1'b0, E_NONE,				1'b0, none);
		add_entry(INSN_JAL,		1'b1, E_NONE,				1'b1, redirect);
		add_entry(INSN_BEQ,		1'b0, E_NONE,				1'b0, none);
		add_entry(INSN_BEQ,		1'b1, E_NONE,				1'b1, redirect);
		add_entry(INSN_LW,		1'b0, E_NONE,				1'b0, none);
		add_entry(INSN_LW,		1'b1, E_LD_PAGE_FAULT,		1'b1, ls_fault);
		add_entry(INSN_SW,		1'b1, E_ST_ACCESS_FAULT,	1'b1, ls_fault);
		add_entry(INSN_LW,		1'b1, E_LD_MISALIGNED,		1'b1, ls_fault);
		add_entry(INSN_SW,		1'b0, E_NONE,				1'b0, none);
		add_entry(INSN_LW,		1'b1, E_I_PAGE_FAULT,		1'b1, i_fault);
		add_entry(INSN_SW,		1'b1, E_I_ACCESS_FAULT,		1'b1, i_fault);
		add_entry(INSN_LW,		1'b1, E_I_MISALIGNED,		1'b1, i_fault);
		add_entry(INSN_LW,		1'b1, E_ILLEGAL_INSTR,		1'b1, kill);
		add_entry(INSN_FENCE,	1'b0, E_NONE,				1'b1, fence);
		add_entry(INSN_FENCE_I,	1'b0, E_NONE,				1'b1, fence_i);
		add_entry(INSN_MRET,	1'b0, E_NONE,				1'b0, none);
		add_entry(INSN_ECALL,	1'b0, E_NONE,				1'b1, redirect);
		add_entry(INSN_EBREAK,	1'b0, E_NONE,				1'b1, kill);
		add_entry(INSN_CSRRW,	1'b0, E_NONE,				1'b0, none);
		add_entry(INSN_ADD,		1'b1, E_ILLEGAL_INSTR,		1'b0, none);	// No trap outside ld/st
		add_entry(INSN_SW,		1'b1, E_ST_PAGE_FAULT,		1'b1, ls_fault);
		add_entry(INSN_SW,		1'b1, E_ST_MISALIGNED,		1'b1, ls_fault);
		add_entry(INSN_LW,		1'b1, E_LD_ACCESS_FAULT,	1'b1, ls_fault);
	endtask

	function automatic int next_actionable(input int idx);
		int i;
		i = idx % table_q.size();
		for (int n = 0; n < table_q.size(); n++) begin
			if (table_q[i].has_cmd) begin
				return i;
			end
			i = (i + 1) % table_q.size();
		end
		return i;
	endfunction

	// One instruction for one cycle, held back while the queue stalls
	task automatic send_instr(input logic [`CTL_ILEN-1:0] instr, input logic exc,
		input except_code_e code);
		int waited;
		waited = 0;
		while (stall_o && waited < STALL_LIMIT) begin
			@(negedge clk_i);
			waited++;
		end
		if (stall_o) begin
			timeouts++;
			$display("Timeout at %0t: stall_o stayed high, instruction %h not sent", $time, instr);
		end else begin
			instr_valid_i	= 1'b1;
			instr_i			= instr;
			except_raised_i	= exc;
			except_code_i	= code;
			@(negedge clk_i);
			instr_valid_i	= 1'b0;
			except_raised_i	= 1'b0;
		end
	endtask

	task automatic apply_entry(input stim_t e);
		if (e.has_cmd) begin
			exp_q.push_back(e.cmd);
		end
		send_instr(e.instr, e.exc, e.code);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || busy_o) && waited < DRAIN_LIMIT) begin
			@(negedge clk_i);
			waited++;
		end
		if (exp_q.size() != 0 || busy_o) begin
			timeouts++;
			$display("Timeout at %0t: %0d commands still missing or FSM stuck busy",
				$time, exp_q.size());
		end
	endtask

	task automatic wait_synch();
		int waited;
		waited = 0;
		while (!cmd_o.synch_l1dc_l2c && waited < DRAIN_LIMIT) begin
			@(negedge clk_i);
			waited++;
		end
		if (!cmd_o.synch_l1dc_l2c) begin
			timeouts++;
			$display("Timeout at %0t: SFENCE sync request never appeared", $time);
		end
	endtask

	// A new command starts on any nonzero change of the word
	always @(negedge clk_i) begin
		if (cmd_o !== '0 && cmd_o !== prev_cmd) begin
			checks++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("error at %0t: unexpected command %h", $time, cmd_o);
			end else begin
				mon_exp = exp_q.pop_front();
				cmds_seen++;
				if (cmd_o !== mon_exp) begin
					errors++;
					$display("error at %0t: command %h, expected %h", $time, cmd_o, mon_exp);
				end
			end
		end
		prev_cmd = cmd_o;
	end

	initial begin
		int hold;
		int idx;
		int sent;
		void'($urandom(32'he742ee98));
		rst_n_i				= 1'b0;
		instr_valid_i		= 1'b0;
		instr_i				= '0;
		except_raised_i		= 1'b0;
		except_code_i		= E_NONE;
		l2c_update_done_i	= 1'b1;
		prev_cmd			= '0;
		errors				= 0;
		timeouts			= 0;
		checks				= 0;
		cmds_seen			= 0;
		build_table();

		exp_q.push_back(make_cmd(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, FLUSH_ALL));
		repeat (10) @(negedge clk_i);
		checks++;
		if (cmd_o !== make_cmd(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, FLUSH_ALL) || busy_o !== 1'b1) begin
			errors++;
			$display("error at %0t: reset command %h busy %b", $time, cmd_o, busy_o);
		end
		rst_n_i = 1'b1;
		wait_drain();
		checks++;
		if (cmd_o !== '0 || stall_o !== 1'b0) begin
			errors++;
			$display("error at %0t: idle command %h stall %b", $time, cmd_o, stall_o);
		end

		// Whole table back to back
		foreach (table_q[i]) begin
			apply_entry(table_q[i]);
		end
		wait_drain();

		// SFENCE.VMA with a slow L2 update
		hold = 2 + int'($urandom % 6);
		l2c_update_done_i = 1'b0;
		exp_q.push_back(make_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, NO_FLUSH));
		exp_q.push_back(make_cmd(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, FLUSH_ALL));
		send_instr(INSN_SFENCE, 1'b0, E_NONE);
		wait_synch();
		repeat (hold) begin
			checks++;
			if (cmd_o.synch_l1dc_l2c !== 1'b1 || busy_o !== 1'b1) begin
				errors++;
				$display("error at %0t: sync dropped while L2 busy, cmd %h", $time, cmd_o);
			end
			@(negedge clk_i);
		end
		l2c_update_done_i = 1'b1;
		wait_drain();

		// Burst behind a blocked SFENCE
		l2c_update_done_i = 1'b0;
		exp_q.push_back(make_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, NO_FLUSH));
		exp_q.push_back(make_cmd(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, FLUSH_ALL));
		send_instr(INSN_SFENCE, 1'b0, E_NONE);
		wait_synch();
		idx = 0;
		sent = 0;
		while (sent < BURST_N && !stall_o) begin
			idx = next_actionable(idx);
			apply_entry(table_q[idx]);
			idx++;
			sent++;
		end
		checks++;
		if (stall_o !== 1'b1) begin
			errors++;
			$display("error at %0t: stall_o low after %0d queued events", $time, sent);
		end
		repeat (4) @(negedge clk_i);
		l2c_update_done_i = 1'b1;
		while (sent < BURST_N) begin
			idx = next_actionable(idx);
			apply_entry(table_q[idx]);
			idx++;
			sent++;
		end
		wait_drain();

		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected commands never appeared", exp_q.size());
		end
		$display("Checks %0d, commands %0d, errors %0d, timeouts %0d",
			checks, cmds_seen, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/ctl_pkg.sv
logic/instr_classifier.sv
logic/event_queue.sv
logic/recovery_fsm.sv
logic/recovery_ctl_top.sv
test/recovery_ctl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the recovery control testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module recovery_ctl_tb \
	-o recovery_ctl_sim > "$BUILD_LOG" 2>&1 \
	&& ./obj_dir/recovery_ctl_sim > "$SIM_LOG" 2>&1 \
	|| { echo "Build or simulation stopped with an error, see $BUILD_LOG and $SIM_LOG"; }

grep -q "^STATUS: PASS$" "$SIM_LOG" 2>/dev/null \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
